//--- ntt_butterfly_2x2.f
ntt_pkg.sv
ntt_mod_mult.sv
ntt_butterfly.sv
ntt_stage_link.sv
ntt_ready_tracker.sv
ntt_butterfly_2x2.sv
tb_ntt_butterfly_2x2_assert.sv
tb_ntt_butterfly_2x2.sv

//--- Bender.yml
package:
  name: ntt_butterfly_2x2

sources:
  - files:
      - ntt_pkg.sv
      - ntt_mod_mult.sv
      - ntt_butterfly.sv
      - ntt_stage_link.sv
      - ntt_ready_tracker.sv
      - ntt_butterfly_2x2.sv
  - target: test
    files:
      - tb_ntt_butterfly_2x2_assert.sv
      - tb_ntt_butterfly_2x2.sv

//--- tb_ntt_butterfly_2x2.sv
`timescale 1ns/10ps
`default_nettype none

module tb_ntt_butterfly_2x2;

    localparam longint Q           = ntt_pkg::NTT_Q;
    localparam int     LANES       = ntt_pkg::NUM_LANES;
    localparam int     PERIOD      = 100;
    localparam int     DRIVE_DLY   = 1;
    localparam int     SEED        = 64833;
    // ct 20, gs 20, pwm 2x8, pwa 8, pws 8, zeroize 7 plus one fresh set
    localparam int     TOTAL_SETS  = 80;
    localparam int     TIMEOUT_CYC = TOTAL_SETS * 10 + 100;

    logic              clk;
    logic              reset_n;
    logic              zeroize;
    logic              enable;
    ntt_pkg::bf_mode_e mode;
    logic              accumulate;
    ntt_pkg::coeff_t   u00, v00, w00, u01, v01, w01, w10, w11;
    ntt_pkg::coeff_t [LANES-1:0] pw_u, pw_v, pw_w;
    ntt_pkg::coeff_t   u20_o, v20_o, u21_o, v21_o;
    ntt_pkg::coeff_t [LANES-1:0] pwo_o;
    logic              ready_o;

    int          cyc = 0;

    ntt_butterfly_2x2 u_dut (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize),
        .enable_i     (enable),
        .mode_i       (mode),
        .accumulate_i (accumulate),
        .u00_i        (u00),
        .v00_i        (v00),
        .w00_i        (w00),
        .u01_i        (u01),
        .v01_i        (v01),
        .w01_i        (w01),
        .w10_i        (w10),
        .w11_i        (w11),
        .pw_u_i       (pw_u),
        .pw_v_i       (pw_v),
        .pw_w_i       (pw_w),
        .u20_o        (u20_o),
        .v20_o        (v20_o),
        .u21_o        (u21_o),
        .v21_o        (v21_o),
        .pwo_o        (pwo_o),
        .ready_o      (ready_o)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    // ------------------------------
    // reference model, mod q
    // ------------------------------
    function automatic longint add_mod(input longint a, input longint b);
        return (a + b) % Q;
    endfunction

    function automatic longint sub_mod(input longint a, input longint b);
        return (a - b + Q) % Q;
    endfunction

    function automatic longint mul_mod(input longint a, input longint b);
        return (a * b) % Q;
    endfunction

    // ct and gs on one pair
    function automatic void bf_model(input ntt_pkg::bf_mode_e m, input longint u,
                                     input longint v, input longint w,
                                     output longint uo, output longint vo);
        if (m == ntt_pkg::ct) begin
            uo = add_mod(u, mul_mod(w, v));
            vo = sub_mod(u, mul_mod(w, v));
        end else begin
            uo = add_mod(u, v);
            vo = mul_mod(sub_mod(u, v), w);
        end
    endfunction

    function automatic ntt_pkg::coeff_t rand_coeff();
        return ntt_pkg::coeff_t'($urandom % ntt_pkg::NTT_Q);
    endfunction

    // every fifth set all zero, the next one all q-1
    function automatic ntt_pkg::coeff_t pick_coeff(input bit edges, input int i);
        if (edges && i % 5 == 0) begin
            return '0;
        end else if (edges && i % 5 == 1) begin
            return ntt_pkg::NTT_Q - 23'd1;
        end
        return rand_coeff();
    endfunction

    // ------------------------------
    // checking
    // ------------------------------
    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic expect_idle(input int n);
        repeat (n) begin
            @(negedge clk);
            check_value("ready_o", ready_o, 0);
        end
    endtask

    initial begin
        #(TIMEOUT_CYC * PERIOD);
        fail_run("watchdog expired before all tests finished");
    end

    // a failed bound assertion ends the run at the next falling edge
    always @(negedge clk) begin
        if (u_dut.u_assert.fail_count != 0) begin
            fail_run("a bound assertion on the DUT failed");
        end
    end

    // ------------------------------
    // stimulus
    // ------------------------------
    task automatic init_inputs();
        reset_n    = 1'b0;
        zeroize    = 1'b0;
        enable     = 1'b0;
        mode       = ntt_pkg::ct;
        accumulate = 1'b0;
        u00 = '0;
        v00 = '0;
        w00 = '0;
        u01 = '0;
        v01 = '0;
        w01 = '0;
        w10 = '0;
        w11 = '0;
        pw_u = '0;
        pw_v = '0;
        pw_w = '0;
    endtask

    task automatic apply_ntt_set(input bit edges, input int i);
        u00 = pick_coeff(edges, i);
        v00 = pick_coeff(edges, i);
        w00 = pick_coeff(edges, i);
        u01 = pick_coeff(edges, i);
        v01 = pick_coeff(edges, i);
        w01 = pick_coeff(edges, i);
        w10 = pick_coeff(edges, i);
        w11 = pick_coeff(edges, i);
    endtask

    task automatic check_after_reset();
        int j;
        repeat (3) begin
            @(negedge clk);
            check_value("ready_o", ready_o, 0);
            check_value("u20_o", u20_o, 0);
            check_value("v20_o", v20_o, 0);
            check_value("u21_o", u21_o, 0);
            check_value("v21_o", v21_o, 0);
            for (j = 0; j < LANES; j++) begin
                check_value($sformatf("pwo_o[%0d]", j), pwo_o[j], 0);
            end
        end
    endtask

    // back-to-back ct or gs sets through the full array
    task automatic stream_ntt(input ntt_pkg::bf_mode_e m, input int n, input bit edges);
        longint exp_q[$];
        int     issue_q[$];
        longint a0, b0, a1, b1, r0, r1, r2, r3;
        int     i;
        int     got;
        fork
            begin
                for (i = 0; i < n; i++) begin
                    @(posedge clk);
                    #DRIVE_DLY;
                    enable = 1'b1;
                    mode   = m;
                    apply_ntt_set(edges, i);
                    bf_model(m, u00, v00, w00, a0, b0);
                    bf_model(m, u01, v01, w01, a1, b1);
                    bf_model(m, a0, a1, w10, r0, r1);
                    bf_model(m, b0, b1, w11, r2, r3);
                    exp_q.push_back(r0);
                    exp_q.push_back(r1);
                    exp_q.push_back(r2);
                    exp_q.push_back(r3);
                    issue_q.push_back(cyc);
                end
                @(posedge clk);
                #DRIVE_DLY;
                enable = 1'b0;
            end
            begin
                got = 0;
                while (got < n) begin
                    @(negedge clk);
                    if (ready_o) begin
                        if (issue_q.size() == 0) begin
                            fail_run("ready_o rose with no ct/gs set in flight");
                        end
                        check_value("ntt latency", cyc - issue_q.pop_front(),
                                    ntt_pkg::NTT_LATENCY);
                        check_value("u20_o", u20_o, exp_q.pop_front());
                        check_value("v20_o", v20_o, exp_q.pop_front());
                        check_value("u21_o", u21_o, exp_q.pop_front());
                        check_value("v21_o", v21_o, exp_q.pop_front());
                        got++;
                    end
                end
            end
        join
        // exactly n ready cycles
        expect_idle(10);
    endtask

    // pointwise sets on all four lanes
    task automatic stream_pw(input ntt_pkg::bf_mode_e m, input bit acc, input int n,
                             input bit edges);
        longint exp_q[$];
        int     issue_q[$];
        longint e;
        int     i;
        int     j;
        int     got;
        fork
            begin
                for (i = 0; i < n; i++) begin
                    @(posedge clk);
                    #DRIVE_DLY;
                    enable     = 1'b1;
                    mode       = m;
                    accumulate = acc;
                    for (j = 0; j < LANES; j++) begin
                        pw_u[j] = rand_coeff();
                        pw_v[j] = rand_coeff();
                        pw_w[j] = rand_coeff();
                        // sums past q and differences below zero
                        if (edges && i % 4 == 0) begin
                            pw_u[j] = ntt_pkg::NTT_Q - 23'd1;
                            pw_v[j] = ntt_pkg::NTT_Q - 23'd1;
                        end else if (edges && i % 4 == 1) begin
                            pw_u[j] = '0;
                            pw_v[j] = ntt_pkg::NTT_Q - 23'd1;
                        end else if (edges && i % 4 == 2) begin
                            pw_u[j] = ntt_pkg::NTT_Q - 23'd1;
                            pw_v[j] = 23'd1;
                        end
                        case (m)
                            ntt_pkg::pwm: begin
                                e = mul_mod(pw_u[j], pw_v[j]);
                                if (acc) begin
                                    e = add_mod(e, pw_w[j]);
                                end
                            end
                            ntt_pkg::pwa: e = add_mod(pw_u[j], pw_v[j]);
                            default: e = sub_mod(pw_u[j], pw_v[j]);
                        endcase
                        exp_q.push_back(e);
                    end
                    issue_q.push_back(cyc);
                end
                @(posedge clk);
                #DRIVE_DLY;
                enable = 1'b0;
            end
            begin
                got = 0;
                while (got < n) begin
                    @(negedge clk);
                    if (ready_o) begin
                        if (issue_q.size() == 0) begin
                            fail_run("ready_o rose with no pointwise set in flight");
                        end
                        check_value("pw latency", cyc - issue_q.pop_front(),
                                    ntt_pkg::BF_LATENCY);
                        for (j = 0; j < LANES; j++) begin
                            check_value($sformatf("pwo_o[%0d]", j), pwo_o[j],
                                        exp_q.pop_front());
                        end
                        got++;
                    end
                end
            end
        join
        expect_idle(10);
    endtask

    // sets in flight are dropped, a fresh set still goes through
    // the oldest set would have come out in the cycle right after zeroize
    task automatic zeroize_stream();
        int i;
        for (i = 0; i < 7; i++) begin
            @(posedge clk);
            #DRIVE_DLY;
            enable = 1'b1;
            mode   = ntt_pkg::ct;
            apply_ntt_set(1'b0, i);
        end
        @(posedge clk);
        #DRIVE_DLY;
        enable  = 1'b0;
        zeroize = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        zeroize = 1'b0;
        @(negedge clk);
        check_value("ready_o", ready_o, 0);
        check_value("u20_o", u20_o, 0);
        check_value("v20_o", v20_o, 0);
        check_value("u21_o", u21_o, 0);
        check_value("v21_o", v21_o, 0);
        expect_idle(12);
        stream_ntt(ntt_pkg::ct, 1, 1'b0);
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        void'($urandom(SEED));
        init_inputs();
        repeat (4) @(posedge clk);
        #DRIVE_DLY;
        reset_n = 1'b1;

        check_after_reset();
        stream_ntt(ntt_pkg::ct, 20, 1'b0);
        stream_ntt(ntt_pkg::gs, 20, 1'b1);
        stream_pw(ntt_pkg::pwm, 1'b0, 8, 1'b0);
        stream_pw(ntt_pkg::pwm, 1'b1, 8, 1'b0);
        stream_pw(ntt_pkg::pwa, 1'b0, 8, 1'b1);
        stream_pw(ntt_pkg::pws, 1'b0, 8, 1'b1);
        zeroize_stream();

        if (u_dut.u_assert.fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_ntt_butterfly_2x2_assert.sv
`timescale 1ns/10ps
`default_nettype none

module tb_ntt_butterfly_2x2_assert (
    input  wire               clk,
    input  wire               reset_n,
    input  wire               zeroize_i,
    input  wire               enable_i,
    input  ntt_pkg::bf_mode_e mode_i,
    input  wire               ready_i
);

    localparam int NL   = ntt_pkg::NTT_LATENCY;
    localparam int HOLD = NL - 1;

    // number of failed assertions
    int fail_count = 0;

    // no results while the pipeline is held in reset
    ready_in_reset: assert property (@(posedge clk) !reset_n |-> !ready_i)
        else begin
            $error("ready_o high while reset is active");
            fail_count++;
        end

    // zeroize discards everything in flight
    ready_after_zeroize: assert property (
        @(posedge clk) disable iff (!reset_n) zeroize_i |=> !ready_i
    ) else begin
        $error("ready_o high the cycle after zeroize");
        fail_count++;
    end

    // ------------------------------
    // ct latency
    // ------------------------------
    ct_enable_to_ready: assert property (
        @(posedge clk) disable iff (!reset_n)
        (enable_i && !zeroize_i && mode_i == ntt_pkg::ct) ##1 (!zeroize_i [*HOLD])
        |=> ready_i
    ) else begin
        $error("ct enable not followed by ready_o after the array latency");
        fail_count++;
    end

    ct_ready_from_enable: assert property (
        @(posedge clk) disable iff (!reset_n)
        (ready_i && mode_i == ntt_pkg::ct) |-> $past(enable_i, NL)
    ) else begin
        $error("ct ready_o without a matching enable");
        fail_count++;
    end

endmodule

bind ntt_butterfly_2x2 tb_ntt_butterfly_2x2_assert u_assert (
    .clk       (clk),
    .reset_n   (reset_n),
    .zeroize_i (zeroize_i),
    .enable_i  (enable_i),
    .mode_i    (mode_i),
    .ready_i   (ready_o)
);

`default_nettype wire

//--- ntt_butterfly_2x2.sv
`timescale 1ns/10ps
`default_nettype none

module ntt_butterfly_2x2 (
    input  wire               clk,
    input  wire               reset_n,
    input  wire               zeroize_i,
    input  wire               enable_i,
    input  ntt_pkg::bf_mode_e mode_i,
    input  wire               accumulate_i,
    input  ntt_pkg::coeff_t   u00_i,
    input  ntt_pkg::coeff_t   v00_i,
    input  ntt_pkg::coeff_t   w00_i,
    input  ntt_pkg::coeff_t   u01_i,
    input  ntt_pkg::coeff_t   v01_i,
    input  ntt_pkg::coeff_t   w01_i,
    input  ntt_pkg::coeff_t   w10_i,
    input  ntt_pkg::coeff_t   w11_i,
    input  ntt_pkg::coeff_t [ntt_pkg::NUM_LANES-1:0] pw_u_i,
    input  ntt_pkg::coeff_t [ntt_pkg::NUM_LANES-1:0] pw_v_i,
    input  ntt_pkg::coeff_t [ntt_pkg::NUM_LANES-1:0] pw_w_i,
    output ntt_pkg::coeff_t   u20_o,
    output ntt_pkg::coeff_t   v20_o,
    output ntt_pkg::coeff_t   u21_o,
    output ntt_pkg::coeff_t   v21_o,
    output ntt_pkg::coeff_t [ntt_pkg::NUM_LANES-1:0] pwo_o,
    output logic              ready_o
);

    ntt_pkg::coeff_t op_u00, op_v00, op_w00;
    ntt_pkg::coeff_t op_u01, op_v01, op_w01;
    ntt_pkg::coeff_t op_u10, op_v10, op_w10;
    ntt_pkg::coeff_t op_u11, op_v11, op_w11;
    ntt_pkg::coeff_t s1_u0, s1_v0, s1_u1, s1_v1;

    // ------------------------------
    // operand routing
    // ------------------------------
    ntt_stage_link u_link (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .mode_i    (mode_i),
        .u00_i     (u00_i),
        .v00_i     (v00_i),
        .w00_i     (w00_i),
        .u01_i     (u01_i),
        .v01_i     (v01_i),
        .w01_i     (w01_i),
        .w10_i     (w10_i),
        .w11_i     (w11_i),
        .s1_u0_i   (s1_u0),
        .s1_v0_i   (s1_v0),
        .s1_u1_i   (s1_u1),
        .s1_v1_i   (s1_v1),
        .pw_u_i    (pw_u_i),
        .pw_v_i    (pw_v_i),
        .pw_w_i    (pw_w_i),
        .op_u00_o  (op_u00),
        .op_v00_o  (op_v00),
        .op_w00_o  (op_w00),
        .op_u01_o  (op_u01),
        .op_v01_o  (op_v01),
        .op_w01_o  (op_w01),
        .op_u10_o  (op_u10),
        .op_v10_o  (op_v10),
        .op_w10_o  (op_w10),
        .op_u11_o  (op_u11),
        .op_v11_o  (op_v11),
        .op_w11_o  (op_w11)
    );

    // ------------------------------
    // stage 1
    // ------------------------------
    ntt_butterfly bf00 (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .mode_i       (mode_i),
        .accumulate_i (accumulate_i),
        .u_i          (op_u00),
        .v_i          (op_v00),
        .w_i          (op_w00),
        .u_o          (s1_u0),
        .v_o          (s1_v0)
    );

    ntt_butterfly bf01 (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .mode_i       (mode_i),
        .accumulate_i (accumulate_i),
        .u_i          (op_u01),
        .v_i          (op_v01),
        .w_i          (op_w01),
        .u_o          (s1_u1),
        .v_o          (s1_v1)
    );

    // ------------------------------
    // stage 2
    // ------------------------------
    ntt_butterfly bf10 (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .mode_i       (mode_i),
        .accumulate_i (accumulate_i),
        .u_i          (op_u10),
        .v_i          (op_v10),
        .w_i          (op_w10),
        .u_o          (u20_o),
        .v_o          (v20_o)
    );

    ntt_butterfly bf11 (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .mode_i       (mode_i),
        .accumulate_i (accumulate_i),
        .u_i          (op_u11),
        .v_i          (op_v11),
        .w_i          (op_w11),
        .u_o          (u21_o),
        .v_o          (v21_o)
    );

    // pointwise lanes come out on each butterfly's u output
    assign pwo_o[0] = s1_u0;
    assign pwo_o[1] = s1_u1;
    assign pwo_o[2] = u20_o;
    assign pwo_o[3] = u21_o;

    ntt_ready_tracker u_ready (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .enable_i  (enable_i),
        .mode_i    (mode_i),
        .ready_o   (ready_o)
    );

endmodule

`default_nettype wire

//--- ntt_ready_tracker.sv
`timescale 1ns/10ps
`default_nettype none

module ntt_ready_tracker (
    input  wire               clk,
    input  wire               reset_n,
    input  wire               zeroize_i,
    input  wire               enable_i,
    input  ntt_pkg::bf_mode_e mode_i,
    output logic              ready_o
);

    localparam int unsigned NL = ntt_pkg::NTT_LATENCY;
    localparam int unsigned BL = ntt_pkg::BF_LATENCY;

    // bit 0 is the oldest entry
    logic [NL-1:0] ready_sr;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ready_sr <= '0;
        end else if (zeroize_i) begin
            ready_sr <= '0;
        end else begin
            case (mode_i)
                // full 2x2 pass
                ntt_pkg::ct,
                ntt_pkg::gs: ready_sr <= {enable_i, ready_sr[NL-1:1]};
                // one butterfly deep
                ntt_pkg::pwm,
                ntt_pkg::pwa,
                ntt_pkg::pws: ready_sr <= {{(NL-BL){1'b0}}, enable_i, ready_sr[BL-1:1]};
                default: ready_sr <= '0;
            endcase
        end
    end

    assign ready_o = ready_sr[0];

endmodule

`default_nettype wire

//--- ntt_stage_link.sv
`timescale 1ns/10ps
`default_nettype none

module ntt_stage_link (
    input  wire               clk,
    input  wire               reset_n,
    input  wire               zeroize_i,
    input  ntt_pkg::bf_mode_e mode_i,
    input  ntt_pkg::coeff_t   u00_i,
    input  ntt_pkg::coeff_t   v00_i,
    input  ntt_pkg::coeff_t   w00_i,
    input  ntt_pkg::coeff_t   u01_i,
    input  ntt_pkg::coeff_t   v01_i,
    input  ntt_pkg::coeff_t   w01_i,
    input  ntt_pkg::coeff_t   w10_i,
    input  ntt_pkg::coeff_t   w11_i,
    input  ntt_pkg::coeff_t   s1_u0_i,
    input  ntt_pkg::coeff_t   s1_v0_i,
    input  ntt_pkg::coeff_t   s1_u1_i,
    input  ntt_pkg::coeff_t   s1_v1_i,
    input  ntt_pkg::coeff_t [ntt_pkg::NUM_LANES-1:0] pw_u_i,
    input  ntt_pkg::coeff_t [ntt_pkg::NUM_LANES-1:0] pw_v_i,
    input  ntt_pkg::coeff_t [ntt_pkg::NUM_LANES-1:0] pw_w_i,
    output ntt_pkg::coeff_t   op_u00_o,
    output ntt_pkg::coeff_t   op_v00_o,
    output ntt_pkg::coeff_t   op_w00_o,
    output ntt_pkg::coeff_t   op_u01_o,
    output ntt_pkg::coeff_t   op_v01_o,
    output ntt_pkg::coeff_t   op_w01_o,
    output ntt_pkg::coeff_t   op_u10_o,
    output ntt_pkg::coeff_t   op_v10_o,
    output ntt_pkg::coeff_t   op_w10_o,
    output ntt_pkg::coeff_t   op_u11_o,
    output ntt_pkg::coeff_t   op_v11_o,
    output ntt_pkg::coeff_t   op_w11_o
);

    logic pw_mode;
    ntt_pkg::coeff_t [ntt_pkg::BF_LATENCY-1:0] w10_q;
    ntt_pkg::coeff_t [ntt_pkg::BF_LATENCY-1:0] w11_q;

    assign pw_mode = mode_i inside {ntt_pkg::pwm, ntt_pkg::pwa, ntt_pkg::pws};

    // stage-2 twiddles wait for the stage-1 results
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            w10_q <= '0;
            w11_q <= '0;
        end else if (zeroize_i) begin
            w10_q <= '0;
            w11_q <= '0;
        end else begin
            w10_q <= {w10_i, w10_q[ntt_pkg::BF_LATENCY-1:1]};
            w11_q <= {w11_i, w11_q[ntt_pkg::BF_LATENCY-1:1]};
        end
    end

    // ------------------------------
    // stage 1 operands
    // ------------------------------
    assign op_u00_o = pw_mode ? pw_u_i[0] : u00_i;
    assign op_v00_o = pw_mode ? pw_v_i[0] : v00_i;
    assign op_w00_o = pw_mode ? pw_w_i[0] : w00_i;
    assign op_u01_o = pw_mode ? pw_u_i[1] : u01_i;
    assign op_v01_o = pw_mode ? pw_v_i[1] : v01_i;
    assign op_w01_o = pw_mode ? pw_w_i[1] : w01_i;

    // ------------------------------
    // stage 2 operands
    // ------------------------------
    // bf10 pairs the two u results, bf11 the two v results
    assign op_u10_o = pw_mode ? pw_u_i[2] : s1_u0_i;
    assign op_v10_o = pw_mode ? pw_v_i[2] : s1_u1_i;
    assign op_w10_o = pw_mode ? pw_w_i[2] : w10_q[0];
    assign op_u11_o = pw_mode ? pw_u_i[3] : s1_v0_i;
    assign op_v11_o = pw_mode ? pw_v_i[3] : s1_v1_i;
    assign op_w11_o = pw_mode ? pw_w_i[3] : w11_q[0];

endmodule

`default_nettype wire

//--- ntt_butterfly.sv
`timescale 1ns/10ps
`default_nettype none

module ntt_butterfly (
    input  wire               clk,
    input  wire               reset_n,
    input  wire               zeroize_i,
    input  ntt_pkg::bf_mode_e mode_i,
    input  wire               accumulate_i,
    input  ntt_pkg::coeff_t   u_i,
    input  ntt_pkg::coeff_t   v_i,
    input  ntt_pkg::coeff_t   w_i,
    output ntt_pkg::coeff_t   u_o,
    output ntt_pkg::coeff_t   v_o
);

    localparam int unsigned CW = ntt_pkg::COEFF_W;

    ntt_pkg::coeff_t sum_f;
    ntt_pkg::coeff_t diff_f;
    ntt_pkg::coeff_t mul_a;
    ntt_pkg::coeff_t mul_b;
    ntt_pkg::coeff_t carry_d;
    ntt_pkg::coeff_t prod;
    ntt_pkg::coeff_t carry;
    ntt_pkg::coeff_t u_d;
    ntt_pkg::coeff_t v_d;
    ntt_pkg::coeff_t u_q;
    ntt_pkg::coeff_t v_q;
    ntt_pkg::coeff_t [ntt_pkg::MULT_LATENCY-1:0] carry_q;

    function automatic ntt_pkg::coeff_t mod_add(ntt_pkg::coeff_t a, ntt_pkg::coeff_t b);
        logic [CW:0] s;
        s = {1'b0, a} + {1'b0, b};
        if (s >= {1'b0, ntt_pkg::NTT_Q}) begin
            s = s - {1'b0, ntt_pkg::NTT_Q};
        end
        return s[CW-1:0];
    endfunction

    function automatic ntt_pkg::coeff_t mod_sub(ntt_pkg::coeff_t a, ntt_pkg::coeff_t b);
        logic [CW:0] d;
        d = {1'b0, a} - {1'b0, b};
        if (a < b) begin
            d = d + {1'b0, ntt_pkg::NTT_Q};
        end
        return d[CW-1:0];
    endfunction

    // ------------------------------
    // front stage, combinational
    // ------------------------------
    assign sum_f  = mod_add(u_i, v_i);
    assign diff_f = mod_sub(u_i, v_i);

    // carry_d is the operand that bypasses the multiplier
    always_comb begin
        mul_a   = '0;
        mul_b   = '0;
        carry_d = '0;
        case (mode_i)
            ntt_pkg::ct: begin
                mul_a   = v_i;
                mul_b   = w_i;
                carry_d = u_i;
            end
            ntt_pkg::gs: begin
                mul_a   = diff_f;
                mul_b   = w_i;
                carry_d = sum_f;
            end
            ntt_pkg::pwm: begin
                mul_a   = u_i;
                mul_b   = v_i;
                carry_d = accumulate_i ? w_i : '0;
            end
            ntt_pkg::pwa: carry_d = sum_f;
            ntt_pkg::pws: carry_d = diff_f;
            default: carry_d = '0;
        endcase
    end

    ntt_mod_mult u_mult (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .a_i       (mul_a),
        .b_i       (mul_b),
        .p_o       (prod)
    );

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            carry_q <= '0;
        end else if (zeroize_i) begin
            carry_q <= '0;
        end else begin
            carry_q <= {carry_d, carry_q[ntt_pkg::MULT_LATENCY-1:1]};
        end
    end

    assign carry = carry_q[0];

    // ------------------------------
    // back stage, registered
    // ------------------------------
    always_comb begin
        u_d = '0;
        v_d = '0;
        case (mode_i)
            ntt_pkg::ct: begin
                u_d = mod_add(carry, prod);
                v_d = mod_sub(carry, prod);
            end
            ntt_pkg::gs: begin
                u_d = carry;
                v_d = prod;
            end
            ntt_pkg::pwm: u_d = mod_add(prod, carry);
            ntt_pkg::pwa,
            ntt_pkg::pws: u_d = carry;
            default: u_d = '0;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            u_q <= '0;
            v_q <= '0;
        end else if (zeroize_i) begin
            u_q <= '0;
            v_q <= '0;
        end else begin
            u_q <= u_d;
            v_q <= v_d;
        end
    end

    assign u_o = u_q;
    assign v_o = v_q;

endmodule

`default_nettype wire

//--- ntt_mod_mult.sv
`timescale 1ns/10ps
`default_nettype none

module ntt_mod_mult (
    input  wire             clk,
    input  wire             reset_n,
    input  wire             zeroize_i,
    input  ntt_pkg::coeff_t a_i,
    input  ntt_pkg::coeff_t b_i,
    output ntt_pkg::coeff_t p_o
);

    localparam int unsigned CW      = ntt_pkg::COEFF_W;
    localparam int unsigned PROD_W  = 2 * CW;
    // 2^23 = 2^13 - 1 mod q
    localparam int unsigned SHIFT   = 13;
    // first fold stays below 2^36 + 2^23
    localparam int unsigned FOLD1_W = 37;
    localparam int unsigned HI2_W   = FOLD1_W - CW;
    // second fold stays below 3q
    localparam int unsigned FOLD2_W = 25;

    logic [PROD_W-1:0]  prod_q;
    logic [FOLD1_W-1:0] fold1_d;
    logic [FOLD1_W-1:0] fold1_q;
    logic [FOLD2_W-1:0] fold2_d;
    logic [FOLD2_W-1:0] fold2_q;
    logic [CW-1:0]      hi1;
    logic [CW-1:0]      lo1;
    logic [HI2_W-1:0]   hi2;
    logic [CW-1:0]      lo2;
    logic [FOLD2_W-1:0] q_ext;
    logic [FOLD2_W-1:0] q2_ext;
    logic [FOLD2_W-1:0] red;

    // fold 1: hi*2^23 + lo -> hi*2^13 - hi + lo
    assign hi1     = prod_q[PROD_W-1:CW];
    assign lo1     = prod_q[CW-1:0];
    assign fold1_d = {1'b0, hi1, {SHIFT{1'b0}}} - FOLD1_W'(hi1) + FOLD1_W'(lo1);

    // fold 2: the 14-bit upper part is split again at bit 10
    // so its top four bits wrap once more through 2^13 - 1
    assign hi2     = fold1_q[FOLD1_W-1:CW];
    assign lo2     = fold1_q[CW-1:0];
    assign fold2_d = {2'b0, hi2[9:0], {SHIFT{1'b0}}}
                   + FOLD2_W'({hi2[HI2_W-1:10], {SHIFT{1'b0}}})
                   - FOLD2_W'(hi2[HI2_W-1:10])
                   - FOLD2_W'(hi2)
                   + FOLD2_W'(lo2);

    assign q_ext  = {2'b0, ntt_pkg::NTT_Q};
    assign q2_ext = {1'b0, ntt_pkg::NTT_Q, 1'b0};

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prod_q  <= '0;
            fold1_q <= '0;
            fold2_q <= '0;
        end else if (zeroize_i) begin
            prod_q  <= '0;
            fold1_q <= '0;
            fold2_q <= '0;
        end else begin
            prod_q  <= a_i * b_i;
            fold1_q <= fold1_d;
            fold2_q <= fold2_d;
        end
    end

    // final correction, value is below 3q here
    always_comb begin
        if (fold2_q >= q2_ext) begin
            red = fold2_q - q2_ext;
        end else if (fold2_q >= q_ext) begin
            red = fold2_q - q_ext;
        end else begin
            red = fold2_q;
        end
    end

    assign p_o = red[CW-1:0];

endmodule

`default_nettype wire

//--- ntt_pkg.sv
`default_nettype none

package ntt_pkg;

    // ------------------------------
    // coefficient format
    // ------------------------------

    // ML-DSA prime, q = 2^23 - 2^13 + 1
    localparam int unsigned COEFF_W = 23;

    typedef logic [COEFF_W-1:0] coeff_t;

    localparam coeff_t NTT_Q = 23'd8380417;

    // number of pointwise lanes, one per butterfly
    localparam int unsigned NUM_LANES = 4;

    // ------------------------------
    // pipeline latencies
    // ------------------------------

    // product register, two fold registers
    localparam int unsigned MULT_LATENCY = 3;

    // multiplier plus the registered back stage
    localparam int unsigned BF_LATENCY = 4;

    // two butterfly stages in series
    localparam int unsigned NTT_LATENCY = 2 * BF_LATENCY;

    // butterfly operations
    typedef enum logic [2:0] {
        ct  = 3'd0,
        gs  = 3'd1,
        pwm = 3'd2,
        pwa = 3'd3,
        pws = 3'd4
    } bf_mode_e;

endpackage

`default_nettype wire
